// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int BWIDTH     = 64,
    parameter int RAM_ADDR_W = 10
) (
    input  wire               CLK,
    input  wire               RST,
    input  wire  [BWIDTH+1:0] m_bus,
    input  wire               m_vld,
    input  wire               m_rdy,
    input  wire  [BWIDTH+1:0] s_bus,
    input  wire               s_vld,
    input  wire               s_rdy,
    output int                err_count,
    output int                done_count
);

    localparam int MASK_W = BWIDTH / 8;
    localparam int ID_W   = BWIDTH - MASK_W - sbus_pkg::HDR_ID_LSB;
    localparam int DEPTH  = 1 << RAM_ADDR_W;

    typedef logic [BWIDTH+1:0]     bus_word_t;
    typedef logic [RAM_ADDR_W-1:0] word_idx_t;

    logic [BWIDTH-1:0]  model [DEPTH];
    bus_word_t          expect_q [$];
    sbus_pkg::hdr_low_t hdr;
    logic [ID_W-1:0]    id;
    logic [MASK_W-1:0]  wr_mask;
    logic               wr_first;
    logic               wr_incr;
    sbus_pkg::addr_t    wr_addr;
    logic               seen_request;
    int                 test_errs;
    string              kind;

    // Converts a byte address to a word index that wraps at the end of the RAM
    function automatic word_idx_t word_index(input sbus_pkg::addr_t addr);
        word_index = word_idx_t'(addr / MASK_W);
    endfunction

    function automatic bus_word_t response_word(input sbus_pkg::tag_t tag,
                                                input logic [ID_W-1:0] rid);
        response_word = '0;
        response_word[BWIDTH+1:BWIDTH] = tag;
        response_word[sbus_pkg::HDR_ID_LSB +: ID_W] = rid;
    endfunction

    task automatic report_value(input string name, input bus_word_t exp, input bus_word_t got);
        $display("Fail %s expected %h got %h", name, exp, got);
        err_count++;
        test_errs++;
    endtask

    task automatic report_text(input string what);
        $display("Error at %0d ns: %s", $time, what);
        err_count++;
        test_errs++;
    endtask

    // Handshakes are sampled mid-cycle and count at the next rising edge
    always @(negedge CLK)
    begin
        bus_word_t exp;
        word_idx_t idx;
        logic      hdr_due;
        int        step;
        if (RST)
        begin
            err_count    = 0;
            done_count   = 0;
            seen_request = 1'b0;
            expect_q.delete();
        end
        else
        begin
            hdr_due = 1'b0;
            if (m_vld)
            begin
                seen_request = 1'b1;
            end
            else if (!seen_request)
            begin
                if (m_rdy)
                    report_value("m_rdy", '0, bus_word_t'(m_rdy));
                if (s_vld)
                    report_value("s_vld", '0, bus_word_t'(s_vld));
            end

            if (m_vld && m_rdy)
            begin
                case (m_bus[BWIDTH+1:BWIDTH])
                    sbus_pkg::TAG_WR_REQ, sbus_pkg::TAG_RD_REQ:
                    begin
                        hdr       = m_bus[sbus_pkg::HDR_ID_LSB-1:0];
                        id        = m_bus[sbus_pkg::HDR_ID_LSB +: ID_W];
                        wr_mask   = m_bus[BWIDTH-1 -: MASK_W];
                        wr_addr   = hdr.addr;
                        wr_incr   = (hdr.incr != 2'b00);
                        wr_first  = 1'b1;
                        test_errs = 0;
                        kind      = m_bus[BWIDTH] ? "write" : "read";
                        if (!m_bus[BWIDTH])
                        begin
                            // The whole read answer is known from the model right now
                            hdr_due = 1'b1;
                            step    = wr_incr ? MASK_W : 0;
                            expect_q.push_back(response_word(sbus_pkg::RSP_RD_HDR, id));
                            for (int i = 0; i <= int'(hdr.count); i++)
                            begin
                                idx = word_index(hdr.addr + sbus_pkg::addr_t'(i * step));
                                exp = {(i == int'(hdr.count)) ? sbus_pkg::RSP_RD_LAST
                                                              : sbus_pkg::RSP_RD_DATA, model[idx]};
                                expect_q.push_back(exp);
                            end
                        end
                    end
                    default:
                    begin
                        idx = word_index(wr_addr);
                        for (int i = 0; i < MASK_W; i++)
                        begin
                            if (!wr_first || wr_mask[i])
                                model[idx][i*8 +: 8] = m_bus[i*8 +: 8];
                        end
                        wr_first = 1'b0;
                        if (wr_incr)
                            wr_addr = wr_addr + sbus_pkg::addr_t'(MASK_W);
                        if (m_bus[BWIDTH+1:BWIDTH] == sbus_pkg::TAG_WR_LAST)
                            expect_q.push_back(response_word(sbus_pkg::RSP_WR_ACK, id));
                    end
                endcase
            end

            if (s_vld && s_rdy)
            begin
                if (expect_q.size() == 0)
                begin
                    report_text($sformatf("response word %h came with none expected", s_bus));
                end
                else
                begin
                    exp = expect_q.pop_front();
                    if (s_bus[BWIDTH+1:BWIDTH] !== exp[BWIDTH+1:BWIDTH])
                        report_value("s_bus tag", bus_word_t'(exp[BWIDTH+1:BWIDTH]),
                                     bus_word_t'(s_bus[BWIDTH+1:BWIDTH]));
                    if (s_bus[BWIDTH-1:0] !== exp[BWIDTH-1:0])
                        report_value("s_bus data", bus_word_t'(exp[BWIDTH-1:0]),
                                     bus_word_t'(s_bus[BWIDTH-1:0]));
                    // An acknowledge or a last read word closes the request
                    if (exp[BWIDTH+1:BWIDTH] == sbus_pkg::RSP_RD_LAST ||
                        exp[BWIDTH+1:BWIDTH] == sbus_pkg::RSP_WR_ACK)
                    begin
                        done_count++;
                        if (test_errs == 0)
                            $display("Test %0d %s id %h passed", done_count, kind, id);
                        else
                            $display("Test %0d %s id %h had %0d errors", done_count, kind, id,
                                     test_errs);
                    end
                end
            end
            else if (hdr_due)
            begin
                report_text("read request taken without a response header in the same cycle");
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int BWIDTH     = 64;
    localparam int RAM_ADDR_W = 10;
    localparam int ROW_W      = 4;
    localparam int MASK_W     = BWIDTH / 8;
    localparam int ID_W       = BWIDTH - MASK_W - sbus_pkg::HDR_ID_LSB;
    localparam int MAX_TESTS  = 32;
    localparam int COLS       = 7;

    logic              CLK = 1'b0;
    logic              RST = 1'b1;
    logic [BWIDTH+1:0] m_bus = '0;
    logic              m_vld = 1'b0;
    logic              m_rdy;
    logic [BWIDTH+1:0] s_bus;
    logic              s_vld;
    logic              s_rdy = 1'b0;

    logic [31:0]       td [COLS*MAX_TESTS];
    int                n_tests = 0;
    int                cycle_limit = 0;
    int                cycles = 0;
    int                err_count;
    int                done_count;
    logic              bp_mode = 1'b0;
    logic              use_bp;
    logic [15:0]       rdy_lfsr = 16'd30443;
    logic [1:0]        rdy_bits;

    sbus_ram_top #(
        .BWIDTH     (BWIDTH),
        .RAM_ADDR_W (RAM_ADDR_W),
        .ROW_W      (ROW_W)
    ) UUT (
        .CLK   (CLK),
        .RST   (RST),
        .m_bus (m_bus),
        .m_vld (m_vld),
        .m_rdy (m_rdy),
        .s_bus (s_bus),
        .s_vld (s_vld),
        .s_rdy (s_rdy)
    );

    tb_checker #(
        .BWIDTH     (BWIDTH),
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_checker (
        .CLK        (CLK),
        .RST        (RST),
        .m_bus      (m_bus),
        .m_vld      (m_vld),
        .m_rdy      (m_rdy),
        .s_bus      (s_bus),
        .s_vld      (s_vld),
        .s_rdy      (s_rdy),
        .err_count  (err_count),
        .done_count (done_count)
    );

    always #4 CLK = ~CLK;

    // Right shifting Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = state >> 1;
        if (state[0])
        begin
            lfsr_step = lfsr_step ^ 16'hB400;
        end
    endfunction

    task automatic make_word(inout logic [15:0] state, output logic [BWIDTH-1:0] word);
        for (int b = 0; b < BWIDTH; b++)
        begin
            word[b] = state[0];
            state   = lfsr_step(state);
        end
    endtask

    function automatic logic [BWIDTH+1:0] make_header(input sbus_pkg::tag_t tag,
            input sbus_pkg::addr_t addr, input sbus_pkg::count_t count, input logic [1:0] incr,
            input logic [ID_W-1:0] id, input logic [MASK_W-1:0] mask);
        sbus_pkg::hdr_low_t low;
        low.incr    = incr;
        low.spare   = '0;
        low.count   = count;
        low.addr    = addr;
        make_header = {tag, mask, id, low};
    endfunction

    // Holds the word on the bus until the bridge takes it
    task automatic send_word(input logic [BWIDTH+1:0] word);
        m_bus = word;
        m_vld = 1'b1;
        @(negedge CLK);
        while (!m_rdy)
            @(negedge CLK);
        @(posedge CLK);
        #1;
    endtask

    task automatic run_test(input int t);
        int                base;
        logic [3:0]        op;
        sbus_pkg::addr_t   addr;
        sbus_pkg::count_t  count;
        logic [1:0]        incr;
        logic [ID_W-1:0]   id;
        logic [MASK_W-1:0] mask;
        logic [15:0]       seed;
        logic [BWIDTH-1:0] data;
        base    = COLS * t;
        op      = td[base][3:0];
        addr    = td[base+1];
        count   = td[base+2][3:0];
        incr    = td[base+3][1:0];
        id      = ID_W'(td[base+4]);
        mask    = MASK_W'(td[base+5]);
        seed    = td[base+6][15:0];
        bp_mode = op[1];
        if (op[0])
        begin
            send_word(make_header(sbus_pkg::TAG_WR_REQ, addr, count, incr, id, mask));
            for (int i = 0; i <= int'(count); i++)
            begin
                make_word(seed, data);
                send_word({(i == int'(count)) ? sbus_pkg::TAG_WR_LAST
                                              : sbus_pkg::TAG_WR_DATA, data});
            end
        end
        else
        begin
            send_word(make_header(sbus_pkg::TAG_RD_REQ, addr, count, incr, id, '0));
        end
        m_vld = 1'b0;
        m_bus = '0;
        // Only one request is in flight, so wait for its response to close
        do
        begin
            @(posedge CLK);
        end
        while (done_count < t + 1);
        #1;
    endtask

    // Back-pressure holds s_rdy low when two random bits are both set
    always @(posedge CLK)
    begin
        use_bp = bp_mode;
        #1;
        if (use_bp)
        begin
            rdy_bits[0] = rdy_lfsr[0];
            rdy_lfsr    = lfsr_step(rdy_lfsr);
            rdy_bits[1] = rdy_lfsr[0];
            rdy_lfsr    = lfsr_step(rdy_lfsr);
            s_rdy       = (rdy_bits != 2'b11);
        end
        else
        begin
            s_rdy = 1'b1;
        end
    end

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Run stopped after %0d cycles with %0d of %0d tests finished",
                     cycles, done_count, n_tests);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        $readmemh("bench/testdata.txt", td);
        while (n_tests < MAX_TESTS && td[COLS*n_tests] != 32'hf)
        begin
            cycle_limit = cycle_limit + 40 * (int'(td[COLS*n_tests+2][3:0]) + 1);
            n_tests++;
        end
        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;
        // A few quiet cycles before the first request
        repeat (4) @(posedge CLK);
        #1;
        for (int t = 0; t < n_tests; t++)
        begin
            run_test(t);
        end
        if (n_tests == 0)
            $display("No test lines were found in bench/testdata.txt");
        $display("Tests finished %0d of %0d, errors %0d", done_count, n_tests, err_count);
        if (n_tests > 0 && err_count == 0 && done_count == n_tests)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/testdata.txt
// op addr count incr id mask seed, one request per line, all values in hex
// op 0 read, 1 write, 2 read and 3 write with random s_rdy, f ends the list
1 00000040 0 1 0001 ff 1234
1 00000040 0 1 0002 5a 0bad
0 00000040 0 1 0003 00 0000
1 00000060 7 1 0004 ff 2468
0 00000060 7 1 0005 00 0000
1 00000200 3 0 0006 ff 1357
0 00000200 3 0 0007 00 0000
3 00000300 5 1 0008 ff 4321
2 00000300 5 1 0009 00 0000
2 00000060 7 1 000a 00 0000
3 00000300 1 1 0010 3c 0c0f
2 00000300 1 1 0011 00 0000
1 000000c0 0 1 000b ff 5555
1 00000400 0 1 000c ff 7777
0 000000c0 0 1 000d 00 0000
0 00000400 0 1 000e 00 0000
0 000000c0 0 0 000f 00 0000
2 00000400 2 0 0012 00 0000
f 00000000 0 0 0000 00 0000

// File: project.f
verilog/sbus_pkg.sv
verilog/sbus_ram_bridge.sv
verilog/row_stall_ram.sv
verilog/sbus_ram_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f project.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim > sim.log 2>&1 \
    || echo "Build or simulation run did not complete"
cat sim.log 2>/dev/null
grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1

// File: verilog/row_stall_ram.sv
`timescale 1ns/1ps
`default_nettype none

module row_stall_ram #(
    parameter int BWIDTH     = 64,
    parameter int RAM_ADDR_W = 10,
    parameter int ROW_W      = 4
) (
    input  wire                      CLK,
    input  wire                      RST,

    input  wire sbus_pkg::ram_ctl_t  ram_ctl,
    input  wire  [BWIDTH-1:0]        wr_mask,
    input  wire  [BWIDTH-1:0]        wr_data,
    output logic                     wait_n_ok,
    output logic [BWIDTH-1:0]        rd_data
);

    // Byte offset bits inside one word
    localparam int OFFS_W = $clog2(BWIDTH / 8);
    localparam int DEPTH  = 1 << RAM_ADDR_W;

    // Row number width, since the words of a row share the upper index bits
    localparam int ROWS_W = RAM_ADDR_W - ROW_W;

    typedef logic [RAM_ADDR_W-1:0] word_idx_t;
    typedef logic [ROWS_W-1:0]     row_idx_t;
    typedef logic [BWIDTH-1:0]     word_t;

    word_t     mem [DEPTH];

    word_idx_t word_idx;
    row_idx_t  row_idx;
    row_idx_t  open_row_q;
    logic      row_open_q;
    logic      row_miss;
    logic      access_ok;
    word_t     merged;

    // Address bits above the RAM depth are ignored
    assign word_idx = ram_ctl.addr[OFFS_W +: RAM_ADDR_W];
    assign row_idx  = word_idx[RAM_ADDR_W-1:ROW_W];

    assign row_miss  = !row_open_q || (row_idx != open_row_q);
    assign wait_n_ok = ram_ctl.cs && row_miss;
    assign access_ok = ram_ctl.cs && !row_miss;

    // A missed access opens its row during the stall cycle, so the
    // same access completes in the cycle after
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            row_open_q <= 1'b0;
            open_row_q <= '0;
        end
        else if (wait_n_ok)
        begin
            row_open_q <= 1'b1;
            open_row_q <= row_idx;
        end
    end

    // Bits under a clear mask bit keep their old value
    assign merged = (mem[word_idx] & ~wr_mask) | (wr_data & wr_mask);

    always_ff @(posedge CLK)
    begin
        if (access_ok && ram_ctl.we)
        begin
            mem[word_idx] <= merged;
        end
    end

    // Read data changes only when a read completes and stays put through stalls
    always_ff @(posedge CLK)
    begin
        if (access_ok && !ram_ctl.we)
        begin
            rd_data <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/sbus_pkg.sv
`default_nettype none

package sbus_pkg;

    // Two tag bits sit above the data on both bus directions
    typedef logic [1:0] tag_t;

    // Request bus tags
    localparam tag_t TAG_RD_REQ  = 2'b00;
    localparam tag_t TAG_WR_REQ  = 2'b01;
    localparam tag_t TAG_WR_DATA = 2'b10;
    localparam tag_t TAG_WR_LAST = 2'b11;

    // Response bus tags
    localparam tag_t RSP_WR_ACK  = 2'b00;
    localparam tag_t RSP_RD_HDR  = 2'b01;
    localparam tag_t RSP_RD_DATA = 2'b10;
    localparam tag_t RSP_RD_LAST = 2'b11;

    typedef logic [31:0] addr_t;

    // Number of read words minus one
    typedef logic [3:0] count_t;

    // Low 41 bits of a request header with the most significant field first
    typedef struct packed {
        logic [1:0] incr;
        logic [2:0] spare;
        count_t     count;
        addr_t      addr;
    } hdr_low_t;

    // The request id starts right above the low header fields and ends
    // below the byte mask, which takes the top BWIDTH/8 bits
    localparam int HDR_ID_LSB = 41;

    // RAM cycle control from the bridge
    typedef struct packed {
        logic  cs;
        logic  we;
        addr_t addr;
    } ram_ctl_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_ACK,
        READ
    } bridge_state_t;

endpackage

`default_nettype wire

// File: verilog/sbus_ram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_ram_bridge #(
    parameter int BWIDTH = 64
) (
    input  wire                 CLK,
    input  wire                 RST,

    input  wire  [BWIDTH+1:0]   m_bus,
    input  wire                 m_vld,
    output logic                m_rdy,

    output logic [BWIDTH+1:0]   s_bus,
    output logic                s_vld,
    input  wire                 s_rdy,

    output sbus_pkg::ram_ctl_t  ram_ctl,
    output logic [BWIDTH-1:0]   wr_mask,
    output logic [BWIDTH-1:0]   wr_data,
    input  wire                 wait_n_ok,
    input  wire  [BWIDTH-1:0]   rd_data
);

    localparam int MASK_W = BWIDTH / 8;
    localparam int ID_W   = BWIDTH - MASK_W - sbus_pkg::HDR_ID_LSB;

    // One bus word worth of bytes
    localparam sbus_pkg::addr_t ADDR_STEP = sbus_pkg::addr_t'(MASK_W);

    typedef logic [ID_W-1:0]   id_t;
    typedef logic [MASK_W-1:0] byte_mask_t;

    sbus_pkg::bridge_state_t state_q;

    // Fields of the word on the request bus
    sbus_pkg::tag_t     m_tag;
    sbus_pkg::hdr_low_t hdr;
    id_t                hdr_id;
    byte_mask_t         hdr_mask;
    sbus_pkg::addr_t    hdr_step;

    // Request context
    id_t                id_q;
    byte_mask_t         mask_q;
    logic               first_q;
    logic               incr_q;
    sbus_pkg::count_t   cnt_q;
    sbus_pkg::addr_t    wr_addr_q;
    sbus_pkg::addr_t    rd_addr_q;
    sbus_pkg::addr_t    cur_step;

    // Set while rd_data holds a completed word that is not yet shown
    logic               rd_have_q;

    logic               wr_req;
    logic               rd_req;
    logic               wr_beat;
    logic               wr_take;
    logic               rd_issue;
    logic               rd_show;
    logic               rd_last;
    logic [BWIDTH-1:0]  mask_bits;

    // Places an id at its header position with all other bits clear
    function automatic logic [BWIDTH-1:0] id_word(input id_t id);
        id_word = '0;
        id_word[sbus_pkg::HDR_ID_LSB +: ID_W] = id;
    endfunction

    assign m_tag    = m_bus[BWIDTH+1:BWIDTH];
    assign hdr      = m_bus[sbus_pkg::HDR_ID_LSB-1:0];
    assign hdr_id   = m_bus[sbus_pkg::HDR_ID_LSB +: ID_W];
    assign hdr_mask = m_bus[BWIDTH-1 -: MASK_W];
    assign hdr_step = (hdr.incr != 2'b00) ? ADDR_STEP : '0;
    assign cur_step = incr_q ? ADDR_STEP : '0;

    // Headers are only recognised in IDLE. A read header also needs the
    // response side ready, since its response header goes out at once
    assign wr_req = (state_q == sbus_pkg::IDLE) && m_vld &&
                    (m_tag == sbus_pkg::TAG_WR_REQ);
    assign rd_req = (state_q == sbus_pkg::IDLE) && m_vld && s_rdy &&
                    (m_tag == sbus_pkg::TAG_RD_REQ);

    // Both data tags have the top bit set
    assign wr_beat = (state_q == sbus_pkg::WRITE) && m_vld && m_tag[1];
    assign wr_take = wr_beat && !wait_n_ok;

    // No read is issued for the last beat because its word is already in rd_data
    assign rd_last  = (cnt_q == '0);
    assign rd_issue = (state_q == sbus_pkg::READ) && s_rdy && (!rd_have_q || !rd_last);
    assign rd_show  = (state_q == sbus_pkg::READ) && s_rdy && rd_have_q && !wait_n_ok;

    assign m_rdy = wr_req || rd_req || wr_take;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state_q   <= sbus_pkg::IDLE;
            first_q   <= 1'b0;
            rd_have_q <= 1'b0;
            cnt_q     <= '0;
        end
        else
        begin
            case (state_q)
                sbus_pkg::IDLE:
                begin
                    if (wr_req)
                    begin
                        state_q <= sbus_pkg::WRITE;
                        first_q <= 1'b1;
                    end
                    else if (rd_req)
                    begin
                        state_q   <= sbus_pkg::READ;
                        cnt_q     <= hdr.count;
                        // A row stall here means the first read is issued again
                        rd_have_q <= !wait_n_ok;
                    end
                end
                sbus_pkg::WRITE:
                begin
                    if (wr_take)
                    begin
                        first_q <= 1'b0;
                        if (m_tag == sbus_pkg::TAG_WR_LAST)
                        begin
                            state_q <= sbus_pkg::WRITE_ACK;
                        end
                    end
                end
                sbus_pkg::WRITE_ACK:
                begin
                    if (s_rdy)
                    begin
                        state_q <= sbus_pkg::IDLE;
                    end
                end
                sbus_pkg::READ:
                begin
                    if (rd_issue && !wait_n_ok)
                    begin
                        rd_have_q <= 1'b1;
                    end
                    if (rd_show)
                    begin
                        if (rd_last)
                        begin
                            state_q   <= sbus_pkg::IDLE;
                            rd_have_q <= 1'b0;
                        end
                        else
                        begin
                            cnt_q <= cnt_q - 4'd1;
                        end
                    end
                end
                default:
                begin
                    state_q <= sbus_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_req || rd_req)
        begin
            incr_q <= (hdr.incr != 2'b00);
        end
        if (wr_req)
        begin
            id_q   <= hdr_id;
            mask_q <= hdr_mask;
        end

        if (wr_req)
        begin
            wr_addr_q <= hdr.addr;
        end
        else if (wr_take)
        begin
            wr_addr_q <= wr_addr_q + cur_step;
        end

        // Holds the address of the next read to issue
        if (rd_req)
        begin
            rd_addr_q <= wait_n_ok ? hdr.addr : hdr.addr + hdr_step;
        end
        else if (rd_issue && !wait_n_ok)
        begin
            rd_addr_q <= rd_addr_q + cur_step;
        end
    end

    // Each mask bit covers one byte lane
    always_comb
    begin
        for (int i = 0; i < MASK_W; i++)
        begin
            mask_bits[i*8 +: 8] = {8{mask_q[i]}};
        end
    end

    always_comb
    begin
        ram_ctl.cs = wr_beat || rd_req || rd_issue;
        ram_ctl.we = wr_beat;
        if (wr_beat)
        begin
            ram_ctl.addr = wr_addr_q;
        end
        else if (rd_req)
        begin
            ram_ctl.addr = hdr.addr;
        end
        else
        begin
            ram_ctl.addr = rd_addr_q;
        end
    end

    // The header mask applies to the first data word only
    assign wr_mask = first_q ? mask_bits : '1;
    assign wr_data = m_bus[BWIDTH-1:0];

    always_comb
    begin
        s_vld = 1'b0;
        s_bus = {sbus_pkg::RSP_WR_ACK, id_word(id_q)};
        case (state_q)
            sbus_pkg::IDLE:
            begin
                if (rd_req)
                begin
                    s_vld = 1'b1;
                    s_bus = {sbus_pkg::RSP_RD_HDR, id_word(hdr_id)};
                end
            end
            sbus_pkg::WRITE_ACK:
            begin
                s_vld = 1'b1;
            end
            sbus_pkg::READ:
            begin
                s_vld = rd_show;
                s_bus = {rd_last ? sbus_pkg::RSP_RD_LAST : sbus_pkg::RSP_RD_DATA, rd_data};
            end
            default:
            begin
                s_vld = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/sbus_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_ram_top #(
    parameter int BWIDTH     = 64,
    parameter int RAM_ADDR_W = 10,
    parameter int ROW_W      = 4
) (
    input  wire                CLK,
    input  wire                RST,

    input  wire  [BWIDTH+1:0]  m_bus,
    input  wire                m_vld,
    output logic               m_rdy,

    output logic [BWIDTH+1:0]  s_bus,
    output logic               s_vld,
    input  wire                s_rdy
);

    // RAM side of the bridge
    sbus_pkg::ram_ctl_t ram_ctl;
    logic [BWIDTH-1:0]  wr_mask;
    logic [BWIDTH-1:0]  wr_data;
    logic [BWIDTH-1:0]  rd_data;
    logic               wait_n_ok;

    sbus_ram_bridge #(
        .BWIDTH     (BWIDTH)
    ) u_bridge (
        .CLK        (CLK),
        .RST        (RST),
        .m_bus      (m_bus),
        .m_vld      (m_vld),
        .m_rdy      (m_rdy),
        .s_bus      (s_bus),
        .s_vld      (s_vld),
        .s_rdy      (s_rdy),
        .ram_ctl    (ram_ctl),
        .wr_mask    (wr_mask),
        .wr_data    (wr_data),
        .wait_n_ok  (wait_n_ok),
        .rd_data    (rd_data)
    );

    row_stall_ram #(
        .BWIDTH     (BWIDTH),
        .RAM_ADDR_W (RAM_ADDR_W),
        .ROW_W      (ROW_W)
    ) u_ram (
        .CLK        (CLK),
        .RST        (RST),
        .ram_ctl    (ram_ctl),
        .wr_mask    (wr_mask),
        .wr_data    (wr_data),
        .wait_n_ok  (wait_n_ok),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire
